//--- design/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

////////////////////////////////////////////////////////////
// widths and counts
`define DATA_WIDTH      8   // register and ram word
`define INSTR_WIDTH     32
`define PC_WIDTH        8
`define RAM_ADDR_WIDTH  10  // 1024 x 8 data ram
`define REG_ADDR_WIDTH  3
`define REG_COUNT       6   // numbers 6 and 7 unused
`define OPCODE_WIDTH    5
`define FLAG_WIDTH      4

////////////////////////////////////////////////////////////
// instruction word fields
`define RAM_ADDR_MSB    31
`define RAM_ADDR_LSB    22
`define IMM_MSB         21
`define IMM_LSB         14
`define OP1_MSB         13
`define OP1_LSB         11
`define OP2_MSB         10
`define OP2_LSB         8
`define OP3_MSB         7
`define OP3_LSB         5
`define OPCODE_MSB      4
`define OPCODE_LSB      0

// flag register bit positions
`define FLAG_ZERO       0
`define FLAG_GREATER    1
`define FLAG_SHIFT      2
`define FLAG_CARRY      3

`endif

//--- design/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

	typedef logic [`INSTR_WIDTH-1:0] instr_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;
	typedef logic [`PC_WIDTH-1:0] pc_t;

	////////////////////////////////////////////////////////////
	// opcodes, gaps are no-ops
	typedef enum logic [`OPCODE_WIDTH-1:0]
	{
		op_eop        = 5'd0,   // end of program
		op_move       = 5'd1,
		op_load_imm   = 5'd2,
		op_add        = 5'd3,
		op_sub        = 5'd4,
		op_and        = 5'd5,
		op_or         = 5'd6,
		op_shl        = 5'd7,
		op_shr        = 5'd9,
		op_store      = 5'd10,
		op_cmp        = 5'd11,
		op_br_carry   = 5'd12,
		op_br_greater = 5'd13,
		op_br_lesser  = 5'd14,  // neither greater nor zero
		op_br_zero    = 5'd15,
		op_br_shift   = 5'd17,
		op_jump       = 5'd18,
		op_load_mem   = 5'd22   // two cycles
	} opcode_t;

	typedef enum logic [2:0]
	{
		br_none,
		br_carry,
		br_greater,
		br_lesser,
		br_zero,
		br_shift,
		br_always
	} branch_cond_t;

endpackage

//--- design/core_pkg.sv
`include "cpu_consts.svh"

package core_pkg;

	typedef logic [`DATA_WIDTH-1:0] data_t;
	typedef logic [`FLAG_WIDTH-1:0] flags_t;  // carry, shift_out, greater, zero

	typedef enum logic [2:0]
	{
		alu_none,   // flags held
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_shl,
		alu_shr,
		alu_cmp
	} alu_func_t;

	// register write data source
	typedef enum logic [1:0]
	{
		wb_alu,
		wb_imm,
		wb_reg,     // read port a, used by move
		wb_mem
	} wb_src_t;

	typedef enum logic [1:0]
	{
		st_run,
		st_load_wait,
		st_halted
	} seq_state_t;

endpackage

//--- design/instr_decode.sv
`include "cpu_consts.svh"

module instr_decode
(
	input  isa_pkg::instr_t          instr,
	output isa_pkg::reg_addr_t       op1,
	output isa_pkg::reg_addr_t       op2,
	output isa_pkg::reg_addr_t       dest,
	output core_pkg::data_t          imm,
	output isa_pkg::pc_t             target,
	output isa_pkg::ram_addr_t       ram_addr,
	output core_pkg::alu_func_t      alu_func,
	output core_pkg::wb_src_t        wb_src,
	output isa_pkg::branch_cond_t    branch_cond,
	output logic                     reg_write_req,
	output logic                     is_load,
	output logic                     is_store,
	output logic                     is_halt
);

	isa_pkg::opcode_t opcode;
	isa_pkg::reg_addr_t op3;

	////////////////////////////////////////////////////////////
	// field extraction
	assign opcode   = isa_pkg::opcode_t'(instr[`OPCODE_MSB:`OPCODE_LSB]);
	assign op1      = instr[`OP1_MSB:`OP1_LSB];
	assign op2      = instr[`OP2_MSB:`OP2_LSB];
	assign op3      = instr[`OP3_MSB:`OP3_LSB];
	assign imm      = instr[`IMM_MSB:`IMM_LSB];
	assign target   = instr[`IMM_LSB+`PC_WIDTH-1:`IMM_LSB];  // low bits of immediate
	assign ram_addr = instr[`RAM_ADDR_MSB:`RAM_ADDR_LSB];

	////////////////////////////////////////////////////////////
	// opcode to control fields
	always_comb
	begin
		dest          = op1;
		alu_func      = core_pkg::alu_none;
		wb_src        = core_pkg::wb_alu;
		branch_cond   = isa_pkg::br_none;
		reg_write_req = 1'b0;
		is_load       = 1'b0;
		is_store      = 1'b0;
		is_halt       = 1'b0;
		case (opcode)
			isa_pkg::op_eop:        is_halt = 1'b1;
			isa_pkg::op_move:
			begin
				dest          = op2;  // op2 gets op1
				wb_src        = core_pkg::wb_reg;
				reg_write_req = 1'b1;
			end
			isa_pkg::op_load_imm:
			begin
				wb_src        = core_pkg::wb_imm;
				reg_write_req = 1'b1;
			end
			isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and, isa_pkg::op_or:
			begin
				dest          = op3;  // three-operand form
				reg_write_req = 1'b1;
			end
			isa_pkg::op_shl, isa_pkg::op_shr: reg_write_req = 1'b1;  // in place
			isa_pkg::op_store:      is_store = 1'b1;
			isa_pkg::op_br_carry:   branch_cond = isa_pkg::br_carry;
			isa_pkg::op_br_greater: branch_cond = isa_pkg::br_greater;
			isa_pkg::op_br_lesser:  branch_cond = isa_pkg::br_lesser;
			isa_pkg::op_br_zero:    branch_cond = isa_pkg::br_zero;
			isa_pkg::op_br_shift:   branch_cond = isa_pkg::br_shift;
			isa_pkg::op_jump:       branch_cond = isa_pkg::br_always;
			isa_pkg::op_load_mem:
			begin
				wb_src        = core_pkg::wb_mem;
				reg_write_req = 1'b1;
				is_load       = 1'b1;
			end
			default: ;              // dropped or undefined, no-op
		endcase

		// alu function, separate from write control
		case (opcode)
			isa_pkg::op_add: alu_func = core_pkg::alu_add;
			isa_pkg::op_sub: alu_func = core_pkg::alu_sub;
			isa_pkg::op_and: alu_func = core_pkg::alu_and;
			isa_pkg::op_or:  alu_func = core_pkg::alu_or;
			isa_pkg::op_shl: alu_func = core_pkg::alu_shl;
			isa_pkg::op_shr: alu_func = core_pkg::alu_shr;
			isa_pkg::op_cmp: alu_func = core_pkg::alu_cmp;
			default: ;
		endcase
	end

endmodule

//--- design/sequencer.sv
`include "cpu_consts.svh"

module sequencer
(
	input  logic                     clock,
	input  logic                     reset,
	input  core_pkg::flags_t         flags,
	input  isa_pkg::pc_t             target,
	input  isa_pkg::ram_addr_t       ram_addr,
	input  isa_pkg::branch_cond_t    branch_cond,
	input  logic                     reg_write_req,
	input  logic                     is_load,
	input  logic                     is_store,
	input  logic                     is_halt,
	output isa_pkg::pc_t             pc,
	output logic                     reg_write,
	output logic                     mem_enable,
	output logic                     mem_write,
	output isa_pkg::ram_addr_t       mem_addr,
	output logic                     halted
);

	core_pkg::seq_state_t state;
	isa_pkg::pc_t pc_inc;
	isa_pkg::pc_t next_pc;
	logic taken;
	logic running;

	////////////////////////////////////////////////////////////
	// branch decision
	always_comb
	begin
		case (branch_cond)
			isa_pkg::br_carry:   taken = flags[`FLAG_CARRY];
			isa_pkg::br_greater: taken = flags[`FLAG_GREATER];
			isa_pkg::br_lesser:  taken = !flags[`FLAG_GREATER] && !flags[`FLAG_ZERO];
			isa_pkg::br_zero:    taken = flags[`FLAG_ZERO];
			isa_pkg::br_shift:   taken = flags[`FLAG_SHIFT];
			isa_pkg::br_always:  taken = 1'b1;
			default:             taken = 1'b0;
		endcase
	end

	assign pc_inc  = pc + 1'b1;
	assign next_pc = taken ? target : pc_inc;

	////////////////////////////////////////////////////////////
	// state machine and program counter
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= core_pkg::st_run;
			pc    <= '0;
		end
		else
		begin
			case (state)
				core_pkg::st_run:
				begin
					if (is_halt)
						state <= core_pkg::st_halted;   // pc frozen from here
					else if (is_load)
						state <= core_pkg::st_load_wait; // pc holds for ram read
					else
						pc <= next_pc;
				end
				core_pkg::st_load_wait:
				begin
					state <= core_pkg::st_run;
					pc    <= pc_inc;
				end
				core_pkg::st_halted: state <= core_pkg::st_halted;
				default:             state <= core_pkg::st_run;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// strobes
	assign running    = (state == core_pkg::st_run);
	assign halted     = (state == core_pkg::st_halted);
	assign mem_enable = running && (is_load || is_store);  // read or write strobe
	assign mem_write  = running && is_store;
	assign mem_addr   = ram_addr;

	// a load writes only once the ram word is back
	assign reg_write = reg_write_req
		&& ((running && !is_load) || (state == core_pkg::st_load_wait));

endmodule

//--- design/register_file.sv
`include "cpu_consts.svh"

module register_file
(
	input  logic                   clock,
	input  logic                   reset,
	input  isa_pkg::reg_addr_t     op1,
	input  isa_pkg::reg_addr_t     op2,
	input  isa_pkg::reg_addr_t     dest,
	input  logic                   reg_write,
	input  core_pkg::wb_src_t      wb_src,
	input  core_pkg::data_t        imm,
	input  core_pkg::data_t        alu_result,
	input  core_pkg::data_t        mem_rdata,
	output core_pkg::data_t        rd_a,
	output core_pkg::data_t        rd_b
);

	core_pkg::data_t regs [`REG_COUNT];
	core_pkg::data_t wr_data;

	// unpopulated numbers read as zero
	assign rd_a = (op1 < `REG_COUNT) ? regs[op1] : '0;
	assign rd_b = (op2 < `REG_COUNT) ? regs[op2] : '0;

	always_comb
	begin
		case (wb_src)
			core_pkg::wb_imm: wr_data = imm;
			core_pkg::wb_reg: wr_data = rd_a;   // move
			core_pkg::wb_mem: wr_data = mem_rdata;
			default:          wr_data = alu_result;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (reg_write && (dest < `REG_COUNT))
			regs[dest] <= wr_data;
	end

endmodule

//--- design/alu.sv
`include "cpu_consts.svh"

module alu
(
	input  logic                   clock,
	input  logic                   reset,
	input  core_pkg::alu_func_t    alu_func,
	input  core_pkg::data_t        a,
	input  core_pkg::data_t        b,
	output core_pkg::data_t        result,
	output core_pkg::flags_t       flags
);

	logic [`DATA_WIDTH:0] sum;   // one extra bit for carry
	logic [`DATA_WIDTH:0] diff;  // msb is the borrow
	core_pkg::flags_t next_flags;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	////////////////////////////////////////////////////////////
	// result and next flags
	always_comb
	begin
		result     = a;
		next_flags = flags;   // unnamed flags held
		case (alu_func)
			core_pkg::alu_add:
			begin
				result                  = sum[`DATA_WIDTH-1:0];
				next_flags[`FLAG_CARRY] = sum[`DATA_WIDTH];
			end
			core_pkg::alu_sub:
			begin
				result                  = diff[`DATA_WIDTH-1:0];
				next_flags[`FLAG_CARRY] = diff[`DATA_WIDTH];
			end
			core_pkg::alu_and: result = a & b;
			core_pkg::alu_or:  result = a | b;
			core_pkg::alu_shl:
			begin
				result                  = a << 1;
				next_flags[`FLAG_SHIFT] = a[`DATA_WIDTH-1];
			end
			core_pkg::alu_shr:
			begin
				result                  = a >> 1;
				next_flags[`FLAG_SHIFT] = a[0];  // bit 0 falls out
			end
			default: ;
		endcase

		// zero follows the result, except for compare
		if (alu_func == core_pkg::alu_cmp)
		begin
			next_flags[`FLAG_GREATER] = (a > b);
			next_flags[`FLAG_ZERO]    = (a == b);
		end
		else if (alu_func != core_pkg::alu_none)
			next_flags[`FLAG_ZERO] = (result == '0);
	end

	////////////////////////////////////////////////////////////
	// flag register
	always_ff @(posedge clock)
	begin
		if (reset)
			flags <= '0;
		else if (alu_func != core_pkg::alu_none)
			flags <= next_flags;
	end

endmodule

//--- design/cpu_top.sv
module cpu_top
(
	input  logic                 clock,
	input  logic                 reset,
	input  isa_pkg::instr_t      instr,
	input  core_pkg::data_t      mem_rdata,
	output isa_pkg::pc_t         pc,
	output logic                 mem_enable,
	output logic                 mem_write,
	output logic                 halted,
	output isa_pkg::ram_addr_t   mem_addr,
	output core_pkg::data_t      mem_wdata
);

	isa_pkg::reg_addr_t op1;
	isa_pkg::reg_addr_t op2;
	isa_pkg::reg_addr_t dest;
	core_pkg::data_t imm;
	isa_pkg::pc_t target;
	isa_pkg::ram_addr_t ram_addr;
	core_pkg::alu_func_t alu_func;
	core_pkg::wb_src_t wb_src;
	isa_pkg::branch_cond_t branch_cond;
	logic reg_write_req;
	logic is_load;
	logic is_store;
	logic is_halt;
	logic reg_write;
	core_pkg::data_t rd_a;
	core_pkg::data_t rd_b;
	core_pkg::data_t alu_result;
	core_pkg::flags_t flags;

	assign mem_wdata = rd_a;   // store writes op1

	instr_decode i_instr_decode
	(
		.instr(instr), .op1(op1), .op2(op2), .dest(dest), .imm(imm), .target(target),
		.ram_addr(ram_addr), .alu_func(alu_func), .wb_src(wb_src),
		.branch_cond(branch_cond), .reg_write_req(reg_write_req), .is_load(is_load),
		.is_store(is_store), .is_halt(is_halt)
	);

	sequencer i_sequencer
	(
		.clock(clock), .reset(reset), .flags(flags), .target(target), .ram_addr(ram_addr),
		.branch_cond(branch_cond), .reg_write_req(reg_write_req), .is_load(is_load),
		.is_store(is_store), .is_halt(is_halt), .pc(pc), .reg_write(reg_write),
		.mem_enable(mem_enable), .mem_write(mem_write), .mem_addr(mem_addr),
		.halted(halted)
	);

	register_file i_register_file
	(
		.clock(clock), .reset(reset), .op1(op1), .op2(op2), .dest(dest),
		.reg_write(reg_write), .wb_src(wb_src), .imm(imm), .alu_result(alu_result),
		.mem_rdata(mem_rdata), .rd_a(rd_a), .rd_b(rd_b)
	);

	alu i_alu
	(
		.clock(clock), .reset(reset), .alu_func(alu_func), .a(rd_a), .b(rd_b),
		.result(alu_result), .flags(flags)
	);

endmodule

//--- testbench/cpu_assert.sv
module cpu_assert
(
	input logic                 clock,
	input logic                 reset,
	input isa_pkg::pc_t         pc,
	input logic                 mem_enable,
	input logic                 mem_write,
	input isa_pkg::ram_addr_t   mem_addr,
	input core_pkg::data_t      mem_wdata,
	input logic                 halted,
	input logic                 checking,     // high once reset is released
	input isa_pkg::pc_t         exp_pc,
	input logic                 exp_en,
	input logic                 exp_we,
	input isa_pkg::ram_addr_t   exp_addr,
	input core_pkg::data_t      exp_data,
	input logic                 exp_halted
);

	timeunit 1ns;
	timeprecision 1ps;

	logic fail_seen;

	initial
		fail_seen = 1'b0;

	////////////////////////////////////////////////////////////
	// reset state
	a_reset: assert property (@(posedge clock) $past(reset) && reset
		|-> pc == '0 && !mem_enable && !mem_write && !halted)
	else
	begin
		fail_seen = 1'b1;
		$error("error reset state: pc %h mem_enable %h mem_write %h halted %h",
			$sampled(pc), $sampled(mem_enable), $sampled(mem_write), $sampled(halted));
	end

	////////////////////////////////////////////////////////////
	// per-cycle behavior against the expected tables
	a_pc: assert property (@(posedge clock) checking |-> pc == exp_pc)
	else
	begin
		fail_seen = 1'b1;
		$error("error pc: got %h expected %h", $sampled(pc), $sampled(exp_pc));
	end

	a_enable: assert property (@(posedge clock) checking |-> mem_enable == exp_en)
	else
	begin
		fail_seen = 1'b1;
		$error("error mem_enable: got %h expected %h", $sampled(mem_enable), $sampled(exp_en));
	end

	a_write: assert property (@(posedge clock) checking |-> mem_write == exp_we)
	else
	begin
		fail_seen = 1'b1;
		$error("error mem_write: got %h expected %h", $sampled(mem_write), $sampled(exp_we));
	end

	a_addr: assert property (@(posedge clock) checking && exp_en |-> mem_addr == exp_addr)
	else
	begin
		fail_seen = 1'b1;
		$error("error mem_addr: got %h expected %h", $sampled(mem_addr), $sampled(exp_addr));
	end

	a_wdata: assert property (@(posedge clock) checking && exp_we |-> mem_wdata == exp_data)
	else
	begin
		fail_seen = 1'b1;
		$error("error mem_wdata: got %h expected %h", $sampled(mem_wdata), $sampled(exp_data));
	end

	a_halted: assert property (@(posedge clock) checking |-> halted == exp_halted)
	else
	begin
		fail_seen = 1'b1;
		$error("error halted: got %h expected %h", $sampled(halted), $sampled(exp_halted));
	end

endmodule

//--- testbench/cpu_tb.sv
`include "cpu_consts.svh"

module cpu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYCLES = 128;

	logic clock;
	logic reset;
	isa_pkg::instr_t instr;
	core_pkg::data_t mem_rdata;
	isa_pkg::pc_t pc;
	logic mem_enable;
	logic mem_write;
	logic halted;
	isa_pkg::ram_addr_t mem_addr;
	core_pkg::data_t mem_wdata;

	isa_pkg::instr_t rom [256];
	core_pkg::data_t ram [1024];
	core_pkg::data_t ram_model [1024];
	core_pkg::data_t reg_model [`REG_COUNT];
	int prog_len;
	int seed;
	int cyc;
	logic checking;

	// expected tables, one entry per cycle after reset
	isa_pkg::pc_t exp_pc [MAX_CYCLES];
	logic exp_en [MAX_CYCLES];
	logic exp_we [MAX_CYCLES];
	isa_pkg::ram_addr_t exp_addr [MAX_CYCLES];
	core_pkg::data_t exp_data [MAX_CYCLES];
	logic exp_halted [MAX_CYCLES];

	isa_pkg::pc_t exp_pc_now;
	logic exp_en_now;
	logic exp_we_now;
	isa_pkg::ram_addr_t exp_addr_now;
	core_pkg::data_t exp_data_now;
	logic exp_halted_now;

	logic cap_en;
	logic cap_we;
	isa_pkg::ram_addr_t cap_addr;
	core_pkg::data_t cap_wdata;

	assign exp_pc_now     = exp_pc[cyc];
	assign exp_en_now     = exp_en[cyc];
	assign exp_we_now     = exp_we[cyc];
	assign exp_addr_now   = exp_addr[cyc];
	assign exp_data_now   = exp_data[cyc];
	assign exp_halted_now = exp_halted[cyc];

	assign instr = rom[pc];   // combinational program rom

	cpu_top i_cpu_top
	(
		.clock(clock), .reset(reset), .instr(instr), .mem_rdata(mem_rdata), .pc(pc),
		.mem_enable(mem_enable), .mem_write(mem_write), .halted(halted),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	bind cpu_top cpu_assert i_cpu_assert
	(
		.clock(clock), .reset(reset), .pc(pc), .mem_enable(mem_enable),
		.mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.halted(halted), .checking(cpu_tb.checking), .exp_pc(cpu_tb.exp_pc_now),
		.exp_en(cpu_tb.exp_en_now), .exp_we(cpu_tb.exp_we_now),
		.exp_addr(cpu_tb.exp_addr_now), .exp_data(cpu_tb.exp_data_now),
		.exp_halted(cpu_tb.exp_halted_now)
	);

	always #50 clock = ~clock;

	////////////////////////////////////////////////////////////
	// ram model, synchronous read
	always @(negedge clock)
	begin
		cap_en    <= mem_enable;   // strobes are stable mid-cycle
		cap_we    <= mem_write;
		cap_addr  <= mem_addr;
		cap_wdata <= mem_wdata;
	end

	always @(posedge clock)
	begin
		#10;
		if (cap_en && cap_we)
			ram[cap_addr] = cap_wdata;
		else if (cap_en)
			mem_rdata = ram[cap_addr];
	end

	function automatic core_pkg::data_t fill_word(input int addr);
		logic [9:0] a;
		a = addr;
		return a[7:0] ^ a[9:2] ^ 8'h3c;   // every address bit matters
	endfunction

	task automatic emit(input logic [4:0] op, input logic [2:0] o1, input logic [2:0] o2,
		input logic [2:0] o3, input logic [7:0] imm, input logic [9:0] addr);
		rom[prog_len] = {addr, imm, o1, o2, o3, op};
		prog_len++;
	endtask

	// branch over one marker load of r5
	task automatic branch_skip(input logic [4:0] op, input logic [7:0] marker);
		emit(op, 0, 0, 0, prog_len + 2, 0);
		emit(isa_pkg::op_load_imm, 5, 0, 0, marker, 0);
	endtask

	////////////////////////////////////////////////////////////
	// program
	task automatic build_program();
		logic [7:0] a;
		logic [7:0] b;
		a = $random(seed);
		b = $random(seed);
		prog_len = 0;
		emit(isa_pkg::op_load_imm, 0, 0, 0, a, 0);
		emit(isa_pkg::op_load_imm, 1, 0, 0, b, 0);
		emit(isa_pkg::op_move, 0, 2, 0, 0, 0);
		emit(isa_pkg::op_store, 2, 0, 0, 0, 10'h010);
		emit(isa_pkg::op_add, 0, 1, 3, 0, 0);
		emit(isa_pkg::op_store, 3, 0, 0, 0, 10'h011);
		emit(isa_pkg::op_sub, 0, 1, 4, 0, 0);
		emit(isa_pkg::op_store, 4, 0, 0, 0, 10'h012);
		emit(isa_pkg::op_and, 0, 1, 3, 0, 0);
		emit(isa_pkg::op_store, 3, 0, 0, 0, 10'h213);
		emit(isa_pkg::op_or, 0, 1, 4, 0, 0);
		emit(isa_pkg::op_store, 4, 0, 0, 0, 10'h314);
		emit(isa_pkg::op_shl, 0, 0, 0, 0, 0);
		emit(isa_pkg::op_store, 0, 0, 0, 0, 10'h015);
		emit(isa_pkg::op_shr, 1, 0, 0, 0, 0);
		emit(isa_pkg::op_store, 1, 0, 0, 0, 10'h016);
		// equal compare, then lesser and greater compares
		emit(isa_pkg::op_load_imm, 2, 0, 0, 8'd5, 0);
		emit(isa_pkg::op_load_imm, 3, 0, 0, 8'd5, 0);
		emit(isa_pkg::op_cmp, 2, 3, 0, 0, 0);
		branch_skip(isa_pkg::op_br_greater, 8'h01);
		branch_skip(isa_pkg::op_br_zero, 8'h02);
		branch_skip(isa_pkg::op_br_lesser, 8'h03);
		emit(isa_pkg::op_load_imm, 4, 0, 0, 8'd3, 0);
		emit(isa_pkg::op_cmp, 4, 2, 0, 0, 0);
		branch_skip(isa_pkg::op_br_lesser, 8'h04);
		branch_skip(isa_pkg::op_br_greater, 8'h05);
		emit(isa_pkg::op_cmp, 2, 4, 0, 0, 0);
		branch_skip(isa_pkg::op_br_greater, 8'h0b);
		branch_skip(isa_pkg::op_br_zero, 8'h0c);
		// carry set, then cleared
		emit(isa_pkg::op_load_imm, 2, 0, 0, 8'hff, 0);
		emit(isa_pkg::op_load_imm, 3, 0, 0, 8'h01, 0);
		emit(isa_pkg::op_add, 2, 3, 4, 0, 0);
		branch_skip(isa_pkg::op_br_carry, 8'h06);
		emit(isa_pkg::op_sub, 3, 3, 4, 0, 0);
		branch_skip(isa_pkg::op_br_carry, 8'h07);
		// shift-out set, then cleared
		emit(isa_pkg::op_shl, 2, 0, 0, 0, 0);
		branch_skip(isa_pkg::op_br_shift, 8'h08);
		emit(isa_pkg::op_load_imm, 3, 0, 0, 8'h02, 0);
		emit(isa_pkg::op_shr, 3, 0, 0, 0, 0);
		branch_skip(isa_pkg::op_br_shift, 8'h09);
		branch_skip(isa_pkg::op_jump, 8'h0a);
		emit(isa_pkg::op_store, 5, 0, 0, 0, 10'h017);
		emit(isa_pkg::op_load_mem, 5, 0, 0, 0, 10'h005);
		emit(isa_pkg::op_store, 5, 0, 0, 0, 10'h018);
		emit(isa_pkg::op_eop, 0, 0, 0, 0, 0);
	endtask

	function automatic core_pkg::data_t read_reg(input logic [2:0] n);
		return (n < `REG_COUNT) ? reg_model[n] : 8'h00;
	endfunction

	task automatic write_reg(input logic [2:0] n, input core_pkg::data_t v);
		if (n < `REG_COUNT)
			reg_model[n] = v;
	endtask

	////////////////////////////////////////////////////////////
	// instruction-level model, fills the expected tables
	task automatic build_expected();
		int c;
		isa_pkg::pc_t mpc;
		logic stop;
		logic fz, fg, fs, fc;
		logic taken;
		logic [31:0] w;
		logic [4:0] op;
		logic [2:0] o1, o2, o3;
		logic [7:0] imm;
		logic [8:0] wide;
		core_pkg::data_t x, y, r;
		mpc = 0;
		stop = 0;
		{fz, fg, fs, fc} = 4'b0;
		for (int i = 0; i < `REG_COUNT; i++)
			reg_model[i] = 8'h00;
		c = 0;
		while (c < MAX_CYCLES)
		begin
			w = rom[mpc];
			op = w[4:0];
			o3 = w[7:5];
			o2 = w[10:8];
			o1 = w[13:11];
			imm = w[21:14];
			x = read_reg(o1);
			y = read_reg(o2);
			exp_pc[c] = mpc;
			exp_en[c] = 1'b0;
			exp_we[c] = 1'b0;
			exp_addr[c] = w[31:22];
			exp_data[c] = x;
			exp_halted[c] = stop;
			taken = 1'b0;
			if (!stop)
			begin
				case (op)
					isa_pkg::op_eop:      stop = 1'b1;
					isa_pkg::op_move:     write_reg(o2, x);
					isa_pkg::op_load_imm: write_reg(o1, imm);
					isa_pkg::op_add, isa_pkg::op_sub:
					begin
						wide = (op == isa_pkg::op_add) ? x + y : {1'b0, x} - {1'b0, y};
						fc = wide[8];   // carry or borrow
						fz = (wide[7:0] == 8'h00);
						write_reg(o3, wide[7:0]);
					end
					isa_pkg::op_and, isa_pkg::op_or:
					begin
						r = (op == isa_pkg::op_and) ? x & y : x | y;
						fz = (r == 8'h00);
						write_reg(o3, r);
					end
					isa_pkg::op_shl, isa_pkg::op_shr:
					begin
						fs = (op == isa_pkg::op_shl) ? x[7] : x[0];
						r = (op == isa_pkg::op_shl) ? {x[6:0], 1'b0} : {1'b0, x[7:1]};
						fz = (r == 8'h00);
						write_reg(o1, r);
					end
					isa_pkg::op_cmp:
					begin
						fg = (x > y);
						fz = (x == y);
					end
					isa_pkg::op_store:
					begin
						exp_en[c] = 1'b1;
						exp_we[c] = 1'b1;
						ram_model[w[31:22]] = x;
					end
					isa_pkg::op_load_mem:
					begin
						exp_en[c] = 1'b1;
						c++;
						exp_pc[c] = mpc;     // pc held for the read
						exp_en[c] = 1'b0;
						exp_we[c] = 1'b0;
						exp_halted[c] = 1'b0;
						write_reg(o1, ram_model[w[31:22]]);
					end
					isa_pkg::op_br_carry:   taken = fc;
					isa_pkg::op_br_greater: taken = fg;
					isa_pkg::op_br_lesser:  taken = !fg && !fz;
					isa_pkg::op_br_zero:    taken = fz;
					isa_pkg::op_br_shift:   taken = fs;
					isa_pkg::op_jump:       taken = 1'b1;
					default: ;
				endcase
				if (!stop)
					mpc = taken ? imm : mpc + 1;
			end
			c++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		mem_rdata = 8'h00;
		cap_en = 1'b0;
		cap_we = 1'b0;
		checking = 1'b0;
		cyc = 0;
		seed = 31;
		for (int i = 0; i < 256; i++)
			rom[i] = '0;
		for (int i = 0; i < 1024; i++)
		begin
			ram[i] = fill_word(i);
			ram_model[i] = fill_word(i);
		end
		ram[5] = 8'ha7;       // word fetched by the load
		ram_model[5] = 8'ha7;
		build_program();
		build_expected();
		repeat (8) @(posedge clock);
		#10;
		reset = 1'b0;
		checking = 1'b1;
		while (!halted)
		begin
			@(posedge clock);
			#10;
			if (cyc < MAX_CYCLES - 1)
				cyc++;
		end
		repeat (4)            // pc and strobes must stay quiet after halt
		begin
			@(posedge clock);
			#10;
			if (cyc < MAX_CYCLES - 1)
				cyc++;
		end
		if (i_cpu_top.i_cpu_assert.fail_seen)
		begin
			$display("Done: errors found");
			$fatal(1, "assertion failures during the run");
		end
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

	// stop at the first failed assertion
	always @(posedge i_cpu_top.i_cpu_assert.fail_seen)
	begin
		$display("Done: errors found");
		$fatal(1, "stopped at first failed check");
	end

	initial
	begin
		wait (checking);
		#((2 * prog_len + 20) * 100);
		$display("timeout, the core did not halt");
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- src.f
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/instr_decode.sv
design/sequencer.sv
design/register_file.sv
design/alu.sv
design/cpu_top.sv
testbench/cpu_assert.sv
testbench/cpu_tb.sv
